// File: bench/fp_adder_props.sv
// handshake properties for the add/subtract pipeline, bound onto the top level
`timescale 1ns/1ps

module fp_adder_props (
	input logic                    clk,
	input logic                    rst_n,
	input logic                    in_valid,
	input logic                    in_ready,
	input logic                    out_valid,
	input logic                    out_ready,
	input fp_format_pkg::fp_word_t result,
	input fp_pipe_pkg::flag_t      flags
);

	// read by the testbench at the end of the run
	int fail_count = 0;
	// out_ready one and two edges back
	logic rdy_d1;
	logic rdy_d2;
	// accepted inputs one to three edges back
	logic [2:0] acc_d;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rdy_d1 <= 1'b0;
			rdy_d2 <= 1'b0;
			acc_d <= '0;
		end else begin
			rdy_d1 <= out_ready;
			rdy_d2 <= rdy_d1;
			acc_d <= {acc_d[1:0], in_valid && in_ready};
		end
	end

	// stalled output holds value and flags
	hold_out: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(result) && $stable(flags))
		else begin
			$error("output changed while stalled");
			fail_count++;
		end

	// sync reset empties the last stage
	reset_clear: assert property (@(posedge clk) !rst_n |=> !out_valid)
		else begin
			$error("out_valid high after reset");
			fail_count++;
		end

	// three cycles of out_ready leave the input open
	drain_ready: assert property (@(posedge clk) disable iff (!rst_n)
		out_ready && rdy_d1 && rdy_d2 |-> in_ready)
		else begin
			$error("in_ready low after three cycles of out_ready");
			fail_count++;
		end

	// accepted on edge t, visible on edge t+3 when not stalled
	fixed_latency: assert property (@(posedge clk) disable iff (!rst_n)
		acc_d[2] && rdy_d2 && rdy_d1 |-> out_valid)
		else begin
			$error("result missing three cycles after acceptance");
			fail_count++;
		end

endmodule

// File: bench/fp_adder_tb.sv
// testbench for the binary32 add/subtract pipeline: random stimulus, reference model, scoreboard
`timescale 1ns/1ps

module fp_adder_tb;

	// about 1200 operations plus stalls at 60% out_ready, with margin
	localparam int max_cycles = 4000;

	logic clk;
	logic rst_n;
	logic in_valid;
	logic in_ready;
	fp_format_pkg::fp_word_t a;
	fp_format_pkg::fp_word_t b;
	logic sub;
	logic out_valid;
	logic out_ready;
	fp_format_pkg::fp_word_t result;
	fp_pipe_pkg::flag_t flags;

	logic [31:0] rng_state;
	logic stall_mode;
	// expected {flags, result} per accepted operation
	logic [35:0] expect_q[$];
	logic [35:0] want;
	int sent;
	int received;
	int errors;
	int cycles;

	fp_adder_top dut_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.a         (a),
		.b         (b),
		.sub       (sub),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.result    (result),
		.flags     (flags)
	);

	bind fp_adder_top fp_adder_props props_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.result    (result),
		.flags     (flags)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// xorshift32
	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'(next_rand() % 32'(hi - lo + 1));
	endfunction

	// normal number, exponent in lo..hi, random mantissa
	function automatic fp_format_pkg::fp_word_t rand_word(input int lo, input int hi, input logic s);
		logic [7:0] e;
		e = 8'(rand_range(lo, hi));
		return {s, e, 23'(next_rand())};
	endfunction

	// exponent within span of x, clamped to the normal range
	function automatic fp_format_pkg::fp_word_t near_word(input fp_format_pkg::fp_word_t x,
			input int span, input logic s);
		int e;
		e = int'(x[30:23]);
		return rand_word((e - span < 1) ? 1 : e - span, (e + span > 254) ? 254 : e + span, s);
	endfunction

	// reference: flush, align with sticky, integer add, normalize, nearest-even, range, specials
	function automatic logic [35:0] model_add(input fp_format_pkg::fp_word_t x,
			input fp_format_pkg::fp_word_t y, input logic s);
		logic sx;
		logic sy;
		logic sbig;
		logic up;
		int ex;
		int ey;
		int ebig;
		int esmall;
		int d;
		int e;
		logic [26:0] fx;
		logic [26:0] fy;
		logic [26:0] fbig;
		logic [26:0] fsmall;
		logic [26:0] lost;
		logic [26:0] f;
		logic [27:0] sum;
		logic [24:0] m;
		fp_pipe_pkg::flag_t fl;
		fl = '0;
		sx = x[31];
		sy = y[31] ^ s;
		ex = int'(x[30:23]);
		ey = int'(y[30:23]);
		if ((ex == 255 && x[22:0] != '0) || (ey == 255 && y[22:0] != '0) ||
				(ex == 255 && ey == 255 && sx != sy)) begin
			fl[fp_pipe_pkg::flag_inv] = 1'b1;
			return {fl, 32'h7FC0_0000};
		end
		if (ex == 255) return {4'h0, sx, 8'hFF, 23'h0};
		if (ey == 255) return {4'h0, sy, 8'hFF, 23'h0};
		// zero exponent counts as zero
		fx = (ex == 0) ? 27'h0 : {1'b1, x[22:0], 3'b000};
		fy = (ey == 0) ? 27'h0 : {1'b1, y[22:0], 3'b000};
		if (ey > ex || (ey == ex && fy > fx)) begin
			sbig = sy;
			ebig = ey;
			esmall = ex;
			fbig = fy;
			fsmall = fx;
		end else begin
			sbig = sx;
			ebig = ex;
			esmall = ey;
			fbig = fx;
			fsmall = fy;
		end
		d = ebig - esmall;
		if (d >= 27) begin
			fsmall = {26'h0, |fsmall};
		end else begin
			lost = fsmall & ((27'h1 << d) - 27'h1);
			fsmall = (fsmall >> d) | {26'h0, |lost};
		end
		if (sx != sy) sum = {1'b0, fbig} - {1'b0, fsmall};
		else sum = {1'b0, fbig} + {1'b0, fsmall};
		if (sum == '0) return {4'h0, 32'h0};
		e = ebig;
		if (sum[27]) begin
			f = {sum[27:2], sum[1] | sum[0]};
			e = e + 1;
		end else begin
			f = sum[26:0];
			while (!f[26]) begin
				f = f << 1;
				e = e - 1;
			end
		end
		up = f[2] && (f[1] || f[0] || f[3]);
		m = {1'b0, f[26:3]} + {24'h0, up};
		if (m[24]) begin
			m = m >> 1;
			e = e + 1;
		end
		if (e >= 255 || e <= 0) begin
			fl[(e >= 255) ? fp_pipe_pkg::flag_ovf : fp_pipe_pkg::flag_unf] = 1'b1;
			fl[fp_pipe_pkg::flag_inx] = 1'b1;
			return (e >= 255) ? {fl, sbig, 8'hFF, 23'h0} : {fl, sbig, 31'h0};
		end
		fl[fp_pipe_pkg::flag_inx] = |f[2:0];
		return {fl, sbig, 8'(e), m[22:0]};
	endfunction

	// next falling edge, new out_ready
	task automatic step();
		@(negedge clk);
		out_ready = stall_mode ? (next_rand() % 32'd10 < 32'd6) : 1'b1;
	endtask

	// hold the operation until the rising edge that takes it
	task automatic send_op(input fp_format_pkg::fp_word_t x, input fp_format_pkg::fp_word_t y,
			input logic s);
		logic taken;
		taken = 1'b0;
		in_valid = 1'b1;
		a = x;
		b = y;
		sub = s;
		while (!taken) begin
			@(posedge clk);
			taken = in_ready;
			if (taken) begin
				expect_q.push_back(model_add(x, y, s));
				sent++;
			end
			step();
		end
		in_valid = 1'b0;
	endtask

	// scoreboard on the edge where the output handshake completes
	always @(posedge clk) begin
		if (rst_n && out_valid && out_ready) begin
			if (expect_q.size() == 0) begin
				$display("result at %0t arrived with no operation pending", $time);
				errors++;
			end else begin
				want = expect_q.pop_front();
				received++;
				assert ({flags, result} == want) else begin
					$display("CHECK FAILED at %0t: got %h flags %b, expected %h flags %b",
						$time, result, flags, want[31:0], want[35:32]);
					errors++;
				end
			end
		end
	end

	initial begin
		cycles = 0;
		while (cycles < max_cycles) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles with %0d results missing", cycles, expect_q.size());
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		fp_format_pkg::fp_word_t x;
		fp_format_pkg::fp_word_t y;
		logic s;
		rst_n = 1'b0;
		in_valid = 1'b0;
		a = '0;
		b = '0;
		sub = 1'b0;
		out_ready = 1'b1;
		stall_mode = 1'b0;
		rng_state = 32'd29;
		sent = 0;
		received = 0;
		errors = 0;
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		// same-sign additions, wide and close exponents
		for (int i = 0; i < 300; i++) begin
			x = rand_word(1, 254, 1'(next_rand()));
			y = (i < 100) ? rand_word(1, 254, x[31]) : near_word(x, 30, x[31]);
			send_op(x, y, 1'b0);
		end
		// effective subtractions, many near-equal
		for (int i = 0; i < 300; i++) begin
			x = rand_word(1, 254, 1'(next_rand()));
			if (i % 3 == 0) y = near_word(x, 4, x[31]);
			else y = x ^ {9'h0, 23'(next_rand()) >> rand_range(0, 22)};
			if (i % 2 == 0) send_op(x, y, 1'b1);
			else send_op(x, y ^ 32'h8000_0000, 1'b0);
		end
		// x - x
		for (int i = 0; i < 20; i++) begin
			x = rand_word(1, 254, 1'(next_rand()));
			send_op(x, x, 1'b1);
		end
		// NaN, inf - inf, inf plus finite, zero exponent
		for (int i = 0; i < 25; i++) begin
			s = 1'(next_rand());
			x = rand_word(1, 254, s);
			y = {~s, 8'hFF, 23'(next_rand()) | 23'h1};
			send_op(y, x, 1'b0);
			send_op(x, y, 1'b1);
			send_op({1'b0, 8'hFF, 23'h0}, {1'b0, 8'hFF, 23'h0}, 1'b1);
			send_op({1'b1, 8'hFF, 23'h0}, {1'b0, 8'hFF, 23'h0}, 1'b0);
			send_op({s, 8'hFF, 23'h0}, x, 1'b1);
			send_op(x, {s, 8'h00, 23'(next_rand())}, 1'b0);
		end
		// overflow at the top, underflow from cancellation at the bottom
		for (int i = 0; i < 40; i++) begin
			x = rand_word(253, 254, 1'(next_rand()));
			y = rand_word(253, 254, x[31]);
			send_op(x, y, 1'b0);
			x = rand_word(1, 3, 1'(next_rand()));
			y = x ^ {9'h0, 23'(next_rand()) >> rand_range(0, 22)};
			send_op(x, y, 1'b1);
		end
		// mixed traffic against random back-pressure
		stall_mode = 1'b1;
		for (int i = 0; i < 300; i++) begin
			s = 1'(next_rand());
			x = rand_word(1, 254, s);
			y = near_word(x, 26, 1'(next_rand()));
			send_op(x, y, s);
		end
		stall_mode = 1'b0;
		// isolated operations for the latency property
		for (int i = 0; i < 20; i++) begin
			x = rand_word(1, 254, 1'(next_rand()));
			send_op(x, near_word(x, 10, x[31]), 1'b0);
			repeat (rand_range(0, 3)) step();
		end
		while (expect_q.size() != 0) step();
		repeat (4) step();
		$display("results %0d of %0d, mismatches %0d, assertion failures %0d",
			received, sent, errors, dut_i.props_i.fail_count);
		if (errors == 0 && dut_i.props_i.fail_count == 0 && received == sent) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: fp_adder.f
rtl/fp_format_pkg.sv
rtl/fp_pipe_pkg.sv
rtl/fp_stage_if.sv
rtl/fp_align.sv
rtl/frac_addsub.sv
rtl/fp_normalize_round.sv
rtl/fp_adder_top.sv
bench/fp_adder_props.sv
bench/fp_adder_tb.sv

// File: rtl/fp_adder_top.sv
// binary32 add/subtract unit: three-stage pipeline with valid/ready handshake on both ends
`timescale 1ns/1ps

module fp_adder_top (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    in_valid,
	output logic                    in_ready,
	input  fp_format_pkg::fp_word_t a,
	input  fp_format_pkg::fp_word_t b,
	input  logic                    sub,
	output logic                    out_valid,
	input  logic                    out_ready,
	output fp_format_pkg::fp_word_t result,
	output fp_pipe_pkg::flag_t      flags
);

	// stage links
	fp_stage_if align_to_add ();
	fp_stage_if add_to_norm ();

	// stage 1, input handshake lands here
	fp_align align_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_valid     (in_valid),
		.in_ready     (in_ready),
		.a            (a),
		.b            (b),
		.sub          (sub),
		.align_to_add (align_to_add)
	);

	// stage 2
	frac_addsub addsub_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.align_to_add (align_to_add),
		.add_to_norm  (add_to_norm)
	);

	// stage 3, drives the output handshake
	fp_normalize_round norm_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.add_to_norm (add_to_norm),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.result      (result),
		.flags       (flags)
	);

endmodule

// File: rtl/fp_align.sv
// alignment stage: unpacks operands, detects specials, swaps by magnitude, shifts with sticky
`timescale 1ns/1ps

module fp_align (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    in_valid,
	output logic                    in_ready,
	input  fp_format_pkg::fp_word_t a,
	input  fp_format_pkg::fp_word_t b,
	input  logic                    sub,
	fp_stage_if.source              align_to_add
);

	logic sign_a;
	logic sign_b;
	fp_format_pkg::exp_t exp_a;
	fp_format_pkg::exp_t exp_b;
	fp_format_pkg::exp_t exp_l;
	fp_format_pkg::exp_t exp_s;
	fp_format_pkg::exp_t exp_diff;
	logic [fp_format_pkg::man_width-1:0] man_a;
	logic [fp_format_pkg::man_width-1:0] man_b;
	logic nan_a;
	logic nan_b;
	logic inf_a;
	logic inf_b;
	logic swap;
	fp_format_pkg::frac_t frac_a;
	fp_format_pkg::frac_t frac_b;
	fp_format_pkg::frac_t frac_l;
	fp_format_pkg::frac_t frac_s;
	fp_format_pkg::frac_t frac_sh;
	fp_format_pkg::frac_t lost_mask;
	logic sticky;
	logic special;
	fp_format_pkg::fp_word_t special_word;
	fp_pipe_pkg::flag_t flags;

	// subtraction is addition with b negated
	assign sign_a = a[31];
	assign sign_b = b[31] ^ sub;
	assign exp_a = a[30:23];
	assign exp_b = b[30:23];

	// all-ones exponent, mantissa decides NaN or infinity
	assign nan_a = (exp_a == fp_format_pkg::exp_t'(fp_format_pkg::exp_max)) && (a[22:0] != '0);
	assign nan_b = (exp_b == fp_format_pkg::exp_t'(fp_format_pkg::exp_max)) && (b[22:0] != '0);
	assign inf_a = (exp_a == fp_format_pkg::exp_t'(fp_format_pkg::exp_max)) && (a[22:0] == '0);
	assign inf_b = (exp_b == fp_format_pkg::exp_t'(fp_format_pkg::exp_max)) && (b[22:0] == '0);

	// subnormals flush to signed zero
	assign man_a = (exp_a == '0) ? '0 : a[22:0];
	assign man_b = (exp_b == '0) ? '0 : b[22:0];

	// hidden bit only on normal numbers, grs bits start clear
	assign frac_a = {exp_a != '0, man_a, {fp_format_pkg::grs_width{1'b0}}};
	assign frac_b = {exp_b != '0, man_b, {fp_format_pkg::grs_width{1'b0}}};

	// equal magnitudes keep a in front
	assign swap = {exp_b, man_b} > {exp_a, man_a};
	assign exp_l = swap ? exp_b : exp_a;
	assign exp_s = swap ? exp_a : exp_b;
	assign frac_l = swap ? frac_b : frac_a;
	assign frac_s = swap ? frac_a : frac_b;

	// never negative after the swap
	assign exp_diff = exp_l - exp_s;

	// bits that fall off the bottom during the right shift
	assign lost_mask = ~(fp_format_pkg::frac_t'('1) << exp_diff);
	assign sticky = |(frac_s & lost_mask);

	always_comb begin
		if (exp_diff >= 8'd27) begin
			// whole fraction shifted out, only sticky survives
			frac_sh = {{($bits(fp_format_pkg::frac_t)-1){1'b0}}, |frac_s};
		end else begin
			frac_sh = (frac_s >> exp_diff) | {{($bits(fp_format_pkg::frac_t)-1){1'b0}}, sticky};
		end
	end

	// specials decide the result here, later stages only forward it
	always_comb begin
		special = 1'b1;
		flags = '0;
		special_word = fp_pipe_pkg::qnan_word;
		if (nan_a || nan_b || (inf_a && inf_b && (sign_a != sign_b))) begin
			// NaN input or inf - inf
			flags[fp_pipe_pkg::flag_inv] = 1'b1;
		end else if (inf_a) begin
			special_word = {sign_a, 8'hFF, {fp_format_pkg::man_width{1'b0}}};
		end else if (inf_b) begin
			special_word = {sign_b, 8'hFF, {fp_format_pkg::man_width{1'b0}}};
		end else begin
			special = 1'b0;
		end
	end

	// output register may load when empty or when it drains this cycle
	assign in_ready = !align_to_add.valid || align_to_add.ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			align_to_add.valid <= 1'b0;
		end else if (in_ready) begin
			align_to_add.valid <= in_valid;
		end
	end

	// payload only changes on a transfer
	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			align_to_add.sign <= swap ? sign_b : sign_a;
			align_to_add.exp <= exp_l;
			align_to_add.frac_a <= frac_l;
			align_to_add.frac_b <= frac_sh;
			align_to_add.eff_sub <= sign_a ^ sign_b;
			align_to_add.special <= special;
			align_to_add.special_word <= special_word;
			align_to_add.flags <= flags;
		end
	end

	// no carry exists before the adder
	assign align_to_add.carry = 1'b0;

endmodule

// File: rtl/fp_format_pkg.sv
// binary32 format package: field widths, exponent limits and the vector types of the datapath
package fp_format_pkg;

	// exponent bias of binary32
	localparam int exp_bias = 127;
	// all-ones exponent, reserved for infinity and NaN
	localparam int exp_max = 2 * exp_bias + 1;
	// stored mantissa bits, hidden bit not counted
	localparam int man_width = 23;
	// guard, round and sticky bits below the mantissa
	localparam int grs_width = 3;

	// one binary32 word
	typedef logic [31:0] fp_word_t;
	// biased exponent as stored
	typedef logic [7:0] exp_t;
	// exponent with headroom for carry and borrow while normalizing
	typedef logic signed [9:0] exp_wide_t;
	// hidden bit, mantissa, then guard/round/sticky
	typedef logic [man_width+grs_width:0] frac_t;
	// fraction sum with carry-out on top
	typedef logic [man_width+grs_width+1:0] sum_t;

endpackage

// File: rtl/fp_normalize_round.sv
// normalize and round stage: leading-zero shift, nearest-even rounding, range checks, packing
`timescale 1ns/1ps

module fp_normalize_round (
	input  logic                    clk,
	input  logic                    rst_n,
	fp_stage_if.sink                add_to_norm,
	output logic                    out_valid,
	input  logic                    out_ready,
	output fp_format_pkg::fp_word_t result,
	output fp_pipe_pkg::flag_t      flags
);

	logic [4:0] lz;
	logic zero_sum;
	fp_format_pkg::frac_t frac;
	fp_format_pkg::frac_t norm;
	fp_format_pkg::exp_wide_t exp_in;
	fp_format_pkg::exp_wide_t exp_n;
	fp_format_pkg::exp_wide_t exp_f;
	logic round_up;
	logic inexact;
	logic [24:0] rounded;
	logic [fp_format_pkg::man_width-1:0] man_f;
	fp_format_pkg::fp_word_t word_n;
	fp_pipe_pkg::flag_t flags_n;

	assign frac = add_to_norm.frac_a;
	assign zero_sum = !add_to_norm.carry && (frac == '0);
	assign exp_in = fp_format_pkg::exp_wide_t'({2'b00, add_to_norm.exp});

	// leading zero count, highest set bit wins
	always_comb begin
		lz = 5'd27;
		for (int i = 0; i < 27; i++) begin
			if (frac[i]) begin
				lz = 5'(26 - i);
			end
		end
	end

	always_comb begin
		if (add_to_norm.carry) begin
			// carry-out, one step right with the dropped bit folded into sticky
			norm = {1'b1, frac[26:2], frac[1] | frac[0]};
			exp_n = exp_in + 10'sd1;
		end else begin
			norm = frac << lz;
			exp_n = exp_in - fp_format_pkg::exp_wide_t'({5'b0, lz});
		end
	end

	// nearest-even from guard, round, sticky and the lsb
	assign round_up = norm[2] && (norm[1] || norm[0] || norm[3]);
	assign inexact = |norm[2:0];
	assign rounded = {1'b0, norm[26:3]} + 25'(round_up);

	// rounding carry-out means renormalize by one
	assign exp_f = exp_n + fp_format_pkg::exp_wide_t'({9'b0, rounded[24]});
	assign man_f = rounded[24] ? rounded[23:1] : rounded[22:0];

	always_comb begin
		flags_n = '0;
		if (add_to_norm.special) begin
			// decided upstream
			word_n = add_to_norm.special_word;
			flags_n = add_to_norm.flags;
		end else if (zero_sum) begin
			// exact cancellation is +0 with no flags
			word_n = '0;
		end else if (exp_f >= fp_format_pkg::exp_wide_t'(fp_format_pkg::exp_max)) begin
			word_n = {add_to_norm.sign, 8'hFF, {fp_format_pkg::man_width{1'b0}}};
			flags_n[fp_pipe_pkg::flag_ovf] = 1'b1;
			flags_n[fp_pipe_pkg::flag_inx] = 1'b1;
		end else if (exp_f <= 10'sd0) begin
			// below normal range, flush to signed zero
			word_n = {add_to_norm.sign, 31'b0};
			flags_n[fp_pipe_pkg::flag_unf] = 1'b1;
			flags_n[fp_pipe_pkg::flag_inx] = 1'b1;
		end else begin
			word_n = {add_to_norm.sign, exp_f[7:0], man_f};
			flags_n[fp_pipe_pkg::flag_inx] = inexact;
		end
	end

	// last register, back-pressure from the output port
	assign add_to_norm.ready = !out_valid || out_ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (add_to_norm.ready) begin
			out_valid <= add_to_norm.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (add_to_norm.valid && add_to_norm.ready) begin
			result <= word_n;
			flags <= flags_n;
		end
	end

endmodule

// File: rtl/fp_pipe_pkg.sv
// pipeline result package: exception flag vector, flag positions and the canonical NaN
package fp_pipe_pkg;

	// overflow, underflow, invalid, inexact
	typedef logic [3:0] flag_t;

	// bit positions inside flag_t
	localparam int flag_ovf = 0;
	localparam int flag_unf = 1;
	localparam int flag_inv = 2;
	localparam int flag_inx = 3;

	// quiet NaN returned for every invalid operation
	localparam logic [31:0] qnan_word = 32'h7FC0_0000;

endpackage

// File: rtl/fp_stage_if.sv
// pipeline stage link: valid/ready handshake carrying one partial add/subtract result
`timescale 1ns/1ps

interface fp_stage_if;

	// handshake
	logic valid;
	logic ready;

	// result sign, taken from the larger operand
	logic sign;
	fp_format_pkg::exp_t exp;
	// larger and aligned smaller fraction, or low sum bits after the adder
	fp_format_pkg::frac_t frac_a;
	fp_format_pkg::frac_t frac_b;
	// carry-out of the fraction adder
	logic carry;
	logic eff_sub;
	// result already decided upstream
	logic special;
	fp_format_pkg::fp_word_t special_word;
	fp_pipe_pkg::flag_t flags;

	modport source (
		output valid, sign, exp, frac_a, frac_b, carry, eff_sub, special, special_word, flags,
		input ready
	);

	modport sink (
		input valid, sign, exp, frac_a, frac_b, carry, eff_sub, special, special_word, flags,
		output ready
	);

endinterface

// File: rtl/frac_addsub.sv
// fraction stage that adds or subtracts the aligned fractions and passes carry-out as overflow
`timescale 1ns/1ps

module frac_addsub (
	input  logic     clk,
	input  logic     rst_n,
	fp_stage_if.sink   align_to_add,
	fp_stage_if.source add_to_norm
);

	fp_format_pkg::sum_t sum;
	logic take;

	// frac_a is never smaller and the difference stays non-negative
	assign sum = align_to_add.eff_sub ?
		{1'b0, align_to_add.frac_a} - {1'b0, align_to_add.frac_b} :
		{1'b0, align_to_add.frac_a} + {1'b0, align_to_add.frac_b};

	// register free or draining
	assign align_to_add.ready = !add_to_norm.valid || add_to_norm.ready;
	assign take = align_to_add.valid && align_to_add.ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			add_to_norm.valid <= 1'b0;
		end else if (align_to_add.ready) begin
			add_to_norm.valid <= align_to_add.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			// bit 27 travels separately as the carry
			add_to_norm.carry <= sum[$bits(fp_format_pkg::sum_t)-1];
			add_to_norm.frac_a <= sum[$bits(fp_format_pkg::frac_t)-1:0];
			add_to_norm.sign <= align_to_add.sign;
			add_to_norm.exp <= align_to_add.exp;
			add_to_norm.special <= align_to_add.special;
			add_to_norm.special_word <= align_to_add.special_word;
			add_to_norm.flags <= align_to_add.flags;
		end
	end

	// second fraction has no meaning after the sum
	assign add_to_norm.frac_b = '0;

endmodule

// File: run_sim.sh
#!/bin/sh
# build the add/subtract testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module fp_adder_tb -f fp_adder.f -Mdir obj_dir
./obj_dir/Vfp_adder_tb > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
if grep -q "SOME TESTS FAILED" sim.log; then
	exit 1
fi
exit 0
